// File: filelist.f
+incdir+hw
hw/cpu_types_pkg.sv
hw/dp_types_pkg.sv
hw/register_file.sv
hw/alu.sv
hw/control_unit.sv
hw/request_unit.sv
hw/datapath.sv
verif/datapath_chk.sv
verif/datapath_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it.
# The exit status of the simulation is the result of the run.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module datapath_tb -Mdir obj_dir -f filelist.f

./obj_dir/Vdatapath_tb

// File: verif/datapath_tb.sv
// testbench for the single-cycle core with a behavioral memory model.
// ihit and dhit come 0 to 2 cycles late by a seeded $random.
// the program sits at word address 0 upward, one table row per word.
// a row states the next PC, the store it makes, or that it must not run.
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module datapath_tb import cpu_types_pkg::*; ();

  localparam int PERIOD      = 40;
  localparam int NROWS       = 30;
  localparam int WATCHDOG_NS = (NROWS * 10 + 20) * PERIOD;

  typedef enum {EV_SKIP, EV_NPC, EV_STORE, EV_HALT} event_t;

  logic   CLK;
  logic   nRST;
  logic   imemREN;
  logic   ihit;
  logic   dmemREN;
  logic   dmemWEN;
  logic   dhit;
  logic   halt;
  word_t  imemaddr;
  word_t  imemload;
  word_t  dmemaddr;
  word_t  dmemstore;
  word_t  dmemload;

  word_t  imem [64];
  word_t  dmem [64];
  word_t  prog_instr [NROWS];
  event_t prog_kind [NROWS];
  word_t  prog_a [NROWS];
  word_t  prog_b [NROWS];
  word_t  store_addr_q [$];
  word_t  store_data_q [$];

  int     seed = 48520;
  word_t  fetch_addr;
  int     fetch_wait;
  logic   data_busy;
  int     data_wait;
  logic   waiting_data;
  logic   waiting_fetch;
  word_t  last_pc;
  int     rows_done;
  int     rows_expected;

  datapath UUT (.*);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic value_error(string msg);
    $display("** Error at %0d ns: %s", $time, msg);
    stop_with_failure();
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the core did not reach halt within %0d ns", WATCHDOG_NS);
    stop_with_failure();
  end

  function automatic word_t enc_i(opcode_t op, regbits_t rs, regbits_t rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t enc_r(regbits_t rs, regbits_t rt, regbits_t rd, funct_t fn);
    return {RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t enc_j(opcode_t op, int row);
    return {op, 26'(row)};
  endfunction

  function automatic word_t sext16(logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic word_t rowaddr(int row);
    return word_t'(row * 4);
  endfunction

  // initial data memory contents.
  function automatic word_t fill_word(word_t addr);
    return {~addr[15:0], addr[15:0]} ^ {addr[31:16], addr[31:16]} ^ 32'h5A5A_0000;
  endfunction

  function automatic int hit_delay();
    return ($random(seed) & 32'h7FFF_FFFF) % 3;
  endfunction

  task automatic set_row(int row, word_t instr, event_t kind, word_t a, word_t b);
    prog_instr[row] = instr;
    prog_kind[row]  = kind;
    prog_a[row]     = a;
    prog_b[row]     = b;
  endtask

  task automatic build_program();
    word_t r1, r2, r3, r4, r5, r6;
    // expected register values.
    r1 = 32'd0 + sext16(16'd5);
    r2 = 32'd0 + sext16(16'hFFF0);
    r3 = 32'd0 | {16'd0, 16'hFFF0};
    r4 = {16'h1234, 16'd0} | {16'd0, 16'h5678};
    r5 = r4 + r1;
    r6 = r1 - r2;
    for (int i = 0; i < NROWS; i++) begin
      set_row(i, 32'd0, EV_SKIP, 32'd0, 32'd0);
    end
    set_row(0,  enc_i(ADDI, 5'd0, 5'd1, 16'd5),     EV_NPC,   rowaddr(1), 32'd0);
    set_row(1,  enc_i(ADDI, 5'd0, 5'd2, 16'hFFF0),  EV_NPC,   rowaddr(2), 32'd0);
    set_row(2,  enc_i(ORI,  5'd0, 5'd3, 16'hFFF0),  EV_NPC,   rowaddr(3), 32'd0);
    set_row(3,  enc_i(SW,   5'd0, 5'd2, 16'h0040),  EV_STORE, 32'h40, r2);
    set_row(4,  enc_i(SW,   5'd0, 5'd3, 16'h0044),  EV_STORE, 32'h44, r3);
    set_row(5,  enc_i(LUI,  5'd0, 5'd4, 16'h1234),  EV_NPC,   rowaddr(6), 32'd0);
    set_row(6,  enc_i(ORI,  5'd4, 5'd4, 16'h5678),  EV_NPC,   rowaddr(7), 32'd0);
    set_row(7,  enc_r(5'd4, 5'd1, 5'd5, ADD),       EV_NPC,   rowaddr(8), 32'd0);
    set_row(8,  enc_r(5'd1, 5'd2, 5'd6, SUB),       EV_NPC,   rowaddr(9), 32'd0);
    set_row(9,  enc_i(SW,   5'd0, 5'd5, 16'h0048),  EV_STORE, 32'h48, r5);
    set_row(10, enc_i(SW,   5'd0, 5'd6, 16'h004C),  EV_STORE, 32'h4C, r6);
    set_row(11, enc_i(SW,   5'd0, 5'd0, 16'h0050),  EV_STORE, 32'h50, 32'd0);
    set_row(12, enc_i(LW,   5'd0, 5'd7, 16'h0080),  EV_NPC,   rowaddr(13), 32'd0);
    set_row(13, enc_i(SW,   5'd0, 5'd7, 16'h0054),  EV_STORE, 32'h54, fill_word(32'h80));
    // branch target is PC+4 plus the word offset.
    set_row(14, enc_i(BEQ,  5'd1, 5'd1, 16'd2),     EV_NPC,   rowaddr(15) + 32'd8, 32'd0);
    set_row(17, enc_i(BNE,  5'd1, 5'd1, 16'd5),     EV_NPC,   rowaddr(18), 32'd0);
    set_row(18, enc_i(BEQ,  5'd1, 5'd2, 16'd5),     EV_NPC,   rowaddr(19), 32'd0);
    set_row(19, enc_i(BNE,  5'd1, 5'd2, 16'd1),     EV_NPC,   rowaddr(20) + 32'd4, 32'd0);
    set_row(21, enc_j(J, 23),                       EV_NPC,   rowaddr(23), 32'd0);
    set_row(23, enc_j(JAL, 27),                     EV_NPC,   rowaddr(27), 32'd0);
    // link register holds the address after the JAL.
    set_row(24, enc_i(SW,   5'd0, 5'd31, 16'h0058), EV_STORE, 32'h58, rowaddr(24));
    set_row(25, {HALT, 26'd0},                      EV_HALT,  rowaddr(26), 32'd0);
    // a store behind HALT that must never issue.
    set_row(26, enc_i(SW,   5'd0, 5'd1, 16'h0060),  EV_SKIP,  32'd0, 32'd0);
    set_row(27, enc_i(ADDI, 5'd0, 5'd8, 16'd7),     EV_NPC,   rowaddr(28), 32'd0);
    set_row(28, enc_i(SW,   5'd0, 5'd8, 16'h005C),  EV_STORE, 32'h5C, 32'd7);
    set_row(29, enc_r(5'd31, 5'd0, 5'd0, JR),       EV_NPC,   rowaddr(24), 32'd0);
  endtask

  // runs on each falling edge to check the last rising edge.
  task automatic check_cycle();
    int row;
    if (waiting_data || waiting_fetch) begin
      assert (imemaddr == last_pc)
        else value_error($sformatf("PC moved to %h without its hit", imemaddr));
    end
    assert (imemREN == !halt)
      else value_error($sformatf("imemREN %b with halt %b", imemREN, halt));
    if (halt) begin
      assert (!dmemREN && !dmemWEN) else value_error("memory request after halt");
    end
    if (imemaddr != last_pc) begin
      row = int'(last_pc >> 2);
      assert (row < NROWS && prog_kind[row] != EV_SKIP)
        else value_error($sformatf("instruction at %h should not run", last_pc));
      if (prog_kind[row] == EV_STORE) begin
        assert (store_addr_q.size() == 1)
          else value_error($sformatf("row %0d made %0d stores", row, store_addr_q.size()));
        assert (store_addr_q[0] == prog_a[row] && store_data_q[0] == prog_b[row])
          else value_error($sformatf("row %0d stored %h to %h, expected %h to %h", row,
                                     store_data_q[0], store_addr_q[0], prog_b[row], prog_a[row]));
        assert (imemaddr == last_pc + 32'd4)
          else value_error($sformatf("row %0d next PC %h", row, imemaddr));
        store_addr_q.delete();
        store_data_q.delete();
      end else begin
        assert (store_addr_q.size() == 0)
          else value_error($sformatf("row %0d made an unexpected store", row));
        assert (imemaddr == prog_a[row])
          else value_error($sformatf("row %0d next PC %h, expected %h", row, imemaddr,
                                     prog_a[row]));
      end
      if (prog_kind[row] == EV_HALT) begin
        assert (halt) else value_error("halt low after HALT");
      end
      rows_done++;
      last_pc = imemaddr;
    end
  endtask

  task automatic drive_memory();
    // a new fetch address starts a new fetch delay.
    if (imemaddr != fetch_addr) begin
      fetch_addr = imemaddr;
      fetch_wait = hit_delay();
    end
    imemload = imem[imemaddr[7:2]];
    if (fetch_wait > 0) begin
      ihit = 1'b0;
      fetch_wait--;
    end else begin
      // the fetch hit does not wait for imemREN.
      ihit = 1'b1;
    end
    // one dhit per request.
    dhit = 1'b0;
    if (dmemREN || dmemWEN) begin
      if (!data_busy) begin
        data_busy = 1'b1;
        data_wait = hit_delay();
      end
      if (data_wait > 0) begin
        data_wait--;
      end else begin
        dhit      = 1'b1;
        data_busy = 1'b0;
        if (dmemWEN) begin
          dmem[dmemaddr[7:2]] = dmemstore;
          store_addr_q.push_back(dmemaddr);
          store_data_q.push_back(dmemstore);
        end else begin
          dmemload = dmem[dmemaddr[7:2]];
        end
      end
    end else begin
      data_busy = 1'b0;
    end
    waiting_data  = (dmemREN || dmemWEN) && !dhit;
    waiting_fetch = !ihit;
  endtask

  initial begin
    nRST          = 1'b0;
    ihit          = 1'b0;
    dhit          = 1'b0;
    imemload      = '0;
    dmemload      = '0;
    fetch_addr    = '1;
    fetch_wait    = 0;
    data_busy     = 1'b0;
    data_wait     = 0;
    waiting_data  = 1'b0;
    waiting_fetch = 1'b0;
    last_pc       = `CPU_PC_INIT;
    rows_done     = 0;
    rows_expected = 0;
    build_program();
    for (int i = 0; i < 64; i++) begin
      imem[i] = 32'd0;
      dmem[i] = fill_word(word_t'(i * 4));
    end
    for (int i = 0; i < NROWS; i++) begin
      imem[i] = prog_instr[i];
      if (prog_kind[i] != EV_SKIP) begin
        rows_expected++;
      end
    end
    repeat (4) @(negedge CLK);
    nRST = 1'b1;
    assert (imemaddr == `CPU_PC_INIT && imemREN)
      else value_error($sformatf("after reset imemaddr %h imemREN %b", imemaddr, imemREN));
    assert (!dmemREN && !dmemWEN && !halt)
      else value_error("request or halt high after reset");
    drive_memory();
    while (!halt) begin
      @(negedge CLK);
      check_cycle();
      drive_memory();
    end
    // a halted core stays quiet.
    repeat (8) begin
      @(negedge CLK);
      check_cycle();
      drive_memory();
    end
    if (rows_done == rows_expected) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("only %0d of %0d program rows completed", rows_done, rows_expected);
      stop_with_failure();
    end
  end

endmodule

// File: verif/datapath_chk.sv
// protocol assertions on the data-memory requests and on halt.
// bound into every datapath instance.
`timescale 1ns/1ps

module datapath_chk (
  input logic CLK,
  input logic nRST,
  input logic dhit,
  input logic dmemREN,
  input logic dmemWEN,
  input logic halt
);

  // one kind of data access at a time.
  a_one_request: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmemREN && dmemWEN))
    else $error("dmemREN and dmemWEN high together");

  a_ren_held: assert property (@(posedge CLK) disable iff (!nRST)
    dmemREN && !dhit |=> dmemREN)
    else $error("dmemREN dropped before dhit");

  a_wen_held: assert property (@(posedge CLK) disable iff (!nRST)
    dmemWEN && !dhit |=> dmemWEN)
    else $error("dmemWEN dropped before dhit");

  // sticky until reset.
  a_halt_held: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> halt)
    else $error("halt fell while out of reset");

endmodule

bind datapath datapath_chk chk (
  .CLK(CLK), .nRST(nRST), .dhit(dhit), .dmemREN(dmemREN), .dmemWEN(dmemWEN), .halt(halt)
);

// File: hw/datapath.sv
// top of the single-cycle core with PC, next-PC and write-back muxes, halt.
// imemload must stay valid for imemaddr while a data request is outstanding.
// loads and stores complete on dhit, everything else on ihit.
// once halt is set, fetch stops and no register write or request follows.
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module datapath import cpu_types_pkg::*, dp_types_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  output logic  imemREN,
  output word_t imemaddr,
  input  word_t imemload,
  input  logic  ihit,
  output logic  dmemREN,
  output logic  dmemWEN,
  output word_t dmemaddr,
  output word_t dmemstore,
  input  word_t dmemload,
  input  logic  dhit,
  output logic  halt
);

  // decoded controls.
  aluop_t   aluop;
  alusrc_t  alusrc;
  regdst_t  regdst;
  regsrc_t  regsrc;
  pcsrc_t   pcsrc;
  logic     extsel;
  logic     regWEN;
  logic     dREN;
  logic     dWEN;
  logic     halt_req;

  word_t    rdat1;
  word_t    rdat2;
  word_t    wdat;
  regbits_t wsel;
  word_t    imm32;
  word_t    alu_b;
  word_t    alu_o;
  logic     zero;

  word_t    cpc;
  word_t    npc;
  word_t    pc4;
  word_t    jaddr;
  word_t    baddr;
  logic     ihit_live;
  logic     complete;

  // completion gates every state update.
  assign ihit_live = ihit & ~halt;
  assign complete  = (dREN | dWEN) ? (dhit & ~halt) : ihit_live;

  assign imm32 = extsel ? {{16{imemload[15]}}, imemload[15:0]} : {16'b0, imemload[15:0]};
  assign alu_b = (alusrc == ALUSRC_IMM) ? imm32 : rdat2;

  assign pc4   = cpc + 32'd4;
  assign jaddr = {pc4[31:28], imemload[25:0], 2'b00};
  assign baddr = pc4 + {imm32[29:0], 2'b00};

  always_comb begin
    case (pcsrc)
      PCSRC_REG: npc = rdat1;
      PCSRC_JMP: npc = jaddr;
      PCSRC_BR:  npc = baddr;
      default:   npc = pc4;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cpc <= word_t'(`CPU_PC_INIT);
    end else if (complete) begin
      cpc <= npc;
    end
  end

  always_comb begin
    case (regdst)
      REGDST_RT: wsel = imemload[20:16];
      REGDST_RA: wsel = regbits_t'(31);
      default:   wsel = imemload[15:11];
    endcase
  end

  always_comb begin
    case (regsrc)
      REGSRC_MEM: wdat = dmemload;
      REGSRC_LUI: wdat = {imemload[15:0], 16'b0};
      REGSRC_PC4: wdat = pc4;
      default:    wdat = alu_o;
    endcase
  end

  // sticky until reset.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (halt_req && complete) begin
      halt <= 1'b1;
    end
  end

  assign imemREN   = ~halt;
  assign imemaddr  = cpc;
  assign dmemaddr  = alu_o;
  assign dmemstore = rdat2;

  register_file rf (
    .CLK(CLK), .nRST(nRST), .WEN(regWEN & complete), .wsel(wsel),
    .rsel1(imemload[25:21]), .rsel2(imemload[20:16]), .wdat(wdat),
    .rdat1(rdat1), .rdat2(rdat2)
  );

  alu alu0 (
    .port_a(rdat1), .port_b(alu_b), .aluop(aluop), .port_o(alu_o),
    .zero(zero), .negative(), .overflow()
  );

  control_unit cu (
    .opcode(opcode_t'(imemload[31:26])), .funct(funct_t'(imemload[5:0])), .zero(zero),
    .aluop(aluop), .alusrc(alusrc), .regdst(regdst), .regsrc(regsrc), .pcsrc(pcsrc),
    .extsel(extsel), .regWEN(regWEN), .dREN(dREN), .dWEN(dWEN), .halt_req(halt_req)
  );

  request_unit ru (
    .CLK(CLK), .nRST(nRST), .ihit(ihit_live), .dhit(dhit), .dREN(dREN), .dWEN(dWEN),
    .dmemREN(dmemREN), .dmemWEN(dmemWEN)
  );

endmodule

// File: hw/request_unit.sv
// data-memory request flops.
// a request rises the cycle after the fetch hit of a load or store
// and stays up until dhit. dhit wins over a new fetch hit.
`timescale 1ns/1ps

module request_unit import cpu_types_pkg::*; (
  input  logic CLK,
  input  logic nRST,
  input  logic ihit,
  input  logic dhit,
  input  logic dREN,
  input  logic dWEN,
  output logic dmemREN,
  output logic dmemWEN
);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dmemREN <= 1'b0;
      dmemWEN <= 1'b0;
    end else if (dhit) begin
      dmemREN <= 1'b0;
      dmemWEN <= 1'b0;
    end else if (ihit) begin
      // set only, a pending request is never dropped by a refetch.
      if (dREN) begin
        dmemREN <= 1'b1;
      end
      if (dWEN) begin
        dmemWEN <= 1'b1;
      end
    end
  end

endmodule

// File: hw/control_unit.sv
// combinational decoder from opcode and funct to the datapath control set.
// SLL and SRL shift rs by rt[4:0], the shamt field is ignored.
// unknown opcodes and functs act as a no-op that falls through to PC+4.
`timescale 1ns/1ps

module control_unit import cpu_types_pkg::*, dp_types_pkg::*; (
  input  opcode_t opcode,
  input  funct_t  funct,
  input  logic    zero,
  output aluop_t  aluop,
  output alusrc_t alusrc,
  output regdst_t regdst,
  output regsrc_t regsrc,
  output pcsrc_t  pcsrc,
  output logic    extsel,
  output logic    regWEN,
  output logic    dREN,
  output logic    dWEN,
  output logic    halt_req
);

  always_comb begin
    // no-op defaults.
    aluop    = ALU_ADD;
    alusrc   = ALUSRC_REG;
    regdst   = REGDST_RD;
    regsrc   = REGSRC_ALU;
    pcsrc    = PCSRC_NPC;
    extsel   = 1'b0;
    regWEN   = 1'b0;
    dREN     = 1'b0;
    dWEN     = 1'b0;
    halt_req = 1'b0;

    case (opcode)
      RTYPE: begin
        regdst = REGDST_RD;
        regWEN = 1'b1;
        case (funct)
          SLL:       aluop = ALU_SLL;
          SRL:       aluop = ALU_SRL;
          ADD, ADDU: aluop = ALU_ADD;
          SUB, SUBU: aluop = ALU_SUB;
          AND:       aluop = ALU_AND;
          OR:        aluop = ALU_OR;
          XOR:       aluop = ALU_XOR;
          NOR:       aluop = ALU_NOR;
          SLT:       aluop = ALU_SLT;
          SLTU:      aluop = ALU_SLTU;
          JR: begin
            pcsrc  = PCSRC_REG;
            regWEN = 1'b0;
          end
          default:   regWEN = 1'b0;
        endcase
      end
      J: pcsrc = PCSRC_JMP;
      JAL: begin
        pcsrc  = PCSRC_JMP;
        regdst = REGDST_RA;
        regsrc = REGSRC_PC4;
        regWEN = 1'b1;
      end
      // branches compare through a subtract and test zero.
      BEQ, BNE: begin
        aluop  = ALU_SUB;
        extsel = 1'b1;
        if ((opcode == BEQ) == zero) begin
          pcsrc = PCSRC_BR;
        end
      end
      ADDI, ADDIU, SLTI, SLTIU: begin
        aluop  = (opcode == SLTI)  ? ALU_SLT :
                 (opcode == SLTIU) ? ALU_SLTU : ALU_ADD;
        alusrc = ALUSRC_IMM;
        extsel = 1'b1;
        regdst = REGDST_RT;
        regWEN = 1'b1;
      end
      // logical immediates are zero extended.
      ANDI, ORI, XORI: begin
        aluop  = (opcode == ANDI) ? ALU_AND :
                 (opcode == ORI)  ? ALU_OR  : ALU_XOR;
        alusrc = ALUSRC_IMM;
        regdst = REGDST_RT;
        regWEN = 1'b1;
      end
      LUI: begin
        regdst = REGDST_RT;
        regsrc = REGSRC_LUI;
        regWEN = 1'b1;
      end
      LW: begin
        alusrc = ALUSRC_IMM;
        extsel = 1'b1;
        regdst = REGDST_RT;
        regsrc = REGSRC_MEM;
        regWEN = 1'b1;
        dREN   = 1'b1;
      end
      SW: begin
        alusrc = ALUSRC_IMM;
        extsel = 1'b1;
        dWEN   = 1'b1;
      end
      HALT: halt_req = 1'b1;
      default: begin
        regWEN = 1'b0;
      end
    endcase
  end

endmodule

// File: hw/alu.sv
// combinational ALU.
// shifts move port_a by port_b[4:0]. overflow is only flagged for add and sub.
`timescale 1ns/1ps

module alu import cpu_types_pkg::*; (
  input  word_t  port_a,
  input  word_t  port_b,
  input  aluop_t aluop,
  output word_t  port_o,
  output logic   zero,
  output logic   negative,
  output logic   overflow
);

  localparam int MSB = $bits(word_t) - 1;

  logic [4:0] shamt;

  assign shamt = port_b[4:0];

  always_comb begin
    port_o   = '0;
    overflow = 1'b0;
    case (aluop)
      ALU_SLL:  port_o = port_a << shamt;
      ALU_SRL:  port_o = port_a >> shamt;
      ALU_ADD: begin
        port_o   = port_a + port_b;
        // same-sign operands giving a result of the other sign.
        overflow = (port_a[MSB] == port_b[MSB]) && (port_o[MSB] != port_a[MSB]);
      end
      ALU_SUB: begin
        port_o   = port_a - port_b;
        overflow = (port_a[MSB] != port_b[MSB]) && (port_o[MSB] != port_a[MSB]);
      end
      ALU_AND:  port_o = port_a & port_b;
      ALU_OR:   port_o = port_a | port_b;
      ALU_XOR:  port_o = port_a ^ port_b;
      ALU_NOR:  port_o = ~(port_a | port_b);
      ALU_SLT:  port_o = word_t'($signed(port_a) < $signed(port_b));
      ALU_SLTU: port_o = word_t'(port_a < port_b);
      default:  port_o = '0;
    endcase
  end

  assign zero     = (port_o == '0);
  assign negative = port_o[MSB];

endmodule

// File: hw/register_file.sv
// 32 x 32 register file, two combinational reads, one write on the rising edge.
// register 0 is never written and reads zero. reads see the old value on a write.
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module register_file import cpu_types_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     WEN,
  input  regbits_t wsel,
  input  regbits_t rsel1,
  input  regbits_t rsel2,
  input  word_t    wdat,
  output word_t    rdat1,
  output word_t    rdat2
);

  word_t regs [`CPU_NREGS];

  // all registers clear on reset.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '{default: '0};
    end else if (WEN && (wsel != '0)) begin
      regs[wsel] <= wdat;
    end
  end

  assign rdat1 = regs[rsel1];
  assign rdat2 = regs[rsel2];

endmodule

// File: hw/dp_types_pkg.sv
// datapath select encodings driven by the control unit.

package dp_types_pkg;

  // next PC source.
  typedef enum logic [2:0] {
    PCSRC_NPC = 3'd0,
    PCSRC_REG = 3'd1,
    PCSRC_JMP = 3'd2,
    PCSRC_BR  = 3'd3
  } pcsrc_t;

  // register write index, rd, rt or the link register.
  typedef enum logic [1:0] {
    REGDST_RD = 2'd0,
    REGDST_RT = 2'd1,
    REGDST_RA = 2'd2
  } regdst_t;

  // write-back data source.
  typedef enum logic [1:0] {
    REGSRC_ALU = 2'd0,
    REGSRC_MEM = 2'd1,
    REGSRC_LUI = 2'd2,
    REGSRC_PC4 = 2'd3
  } regsrc_t;

  // alu port b source.
  typedef enum logic {ALUSRC_REG = 1'b0, ALUSRC_IMM = 1'b1} alusrc_t;

endpackage

// File: hw/cpu_types_pkg.sv
// instruction-set types for the MIPS subset.
// opcode and funct values follow the standard MIPS encoding.
`include "cpu_cfg.svh"

package cpu_types_pkg;

  // data and address word.
  typedef logic [`CPU_WORD_W-1:0] word_t;

  // register index.
  typedef logic [4:0] regbits_t;

  // primary opcodes, bits [31:26].
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    JAL   = 6'b000011,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDI  = 6'b001000,
    ADDIU = 6'b001001,
    SLTI  = 6'b001010,
    SLTIU = 6'b001011,
    ANDI  = 6'b001100,
    ORI   = 6'b001101,
    XORI  = 6'b001110,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = `CPU_HALT_OP
  } opcode_t;

  // r-type function field, bits [5:0].
  typedef enum logic [5:0] {
    SLL  = 6'b000000,
    SRL  = 6'b000010,
    JR   = 6'b001000,
    ADD  = 6'b100000,
    ADDU = 6'b100001,
    SUB  = 6'b100010,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    XOR  = 6'b100110,
    NOR  = 6'b100111,
    SLT  = 6'b101010,
    SLTU = 6'b101011
  } funct_t;

  // alu operations.
  typedef enum logic [3:0] {
    ALU_SLL  = 4'b0000,
    ALU_SRL  = 4'b0001,
    ALU_ADD  = 4'b0010,
    ALU_SUB  = 4'b0011,
    ALU_AND  = 4'b0100,
    ALU_OR   = 4'b0101,
    ALU_XOR  = 4'b0110,
    ALU_NOR  = 4'b0111,
    ALU_SLT  = 4'b1010,
    ALU_SLTU = 4'b1011
  } aluop_t;

endpackage

// File: hw/cpu_cfg.svh
// core configuration for the single-cycle MIPS subset.
// word width and register count follow the MIPS encoding and are not free.
// the PC reset value must be word aligned.
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data and address width.
`define CPU_WORD_W 32

// architectural registers, index 0 reads as zero.
`define CPU_NREGS 32

// fetch address after reset.
`define CPU_PC_INIT 32'h0000_0000

// primary opcode that stops the core.
`define CPU_HALT_OP 6'b111111

`endif
